// File: sources.f
+incdir+hdl
hdl/core_bus_pkg.sv
hdl/axi_bus_pkg.sv
hdl/bus_addr_decode.sv
hdl/bus_txn_exec.sv
hdl/bus_resp_route.sv
hdl/clint_timer.sv
hdl/uart_tx_reg.sv
hdl/bus_top.sv
tests/bus_checker.sv
tests/bus_props.sv
tests/bus_tb.sv

// File: tests/bus_tb.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module bus_tb;

  localparam int ROWS = 15;
  localparam int WATCHDOG_NS = (ROWS * 40 + 8) * 20;
  localparam logic [31:0] ERR_ADDR = 32'h8000_0200;

  logic clk = 1'b0;
  logic rst = 1'b1;
  core_bus_pkg::core_req_t ifu_req;
  core_bus_pkg::core_req_t lsu_req;
  core_bus_pkg::core_rsp_t ifu_rsp;
  core_bus_pkg::core_rsp_t lsu_rsp;
  axi_bus_pkg::axi_ar_t ar;
  axi_bus_pkg::axi_aw_t aw;
  axi_bus_pkg::axi_w_t  w;
  axi_bus_pkg::axi_r_t  r;
  axi_bus_pkg::axi_b_t  b;
  logic arready;
  logic awready;
  logic wready;
  logic [1:0] arburst, awburst;
  logic [7:0] arlen, awlen;
  logic [3:0] arid, awid;
  logic rready, bready;
  logic [7:0] uart_data;
  logic uart_valid;
  logic local_acc;

  // memory model and its handshake bookkeeping
  logic [63:0] mem [0:255];
  logic [31:0] rnd_state = 32'h8275_e508;
  int ar_cnt, aw_cnt, w_cnt;
  logic ar_hs, aw_hs, w_hs, aw_got, w_got;
  logic [31:0] ar_addr, aw_addr;
  logic [63:0] w_data;
  logic [7:0]  w_strb;

  // stimulus table
  logic [95:0] t_name [ROWS];
  int          t_port [ROWS];
  logic        t_write [ROWS];
  logic [31:0] t_addr [ROWS];
  logic [31:0] t_wdata [ROWS];
  logic [3:0]  t_strb [ROWS];
  logic [31:0] t_exp [ROWS];
  int          n_rows = 0;
  logic [31:0] last_lo;
  logic        seen_lo = 1'b0;

  always #10 clk = ~clk;

  bus_top u_dut (
    .clk (clk), .rst (rst),
    .ifu_req_i (ifu_req), .ifu_rsp_o (ifu_rsp),
    .lsu_req_i (lsu_req), .lsu_rsp_o (lsu_rsp),
    .ar_o (ar), .arburst_o (arburst), .arlen_o (arlen), .arid_o (arid),
    .arready_i (arready), .r_i (r), .rready_o (rready),
    .aw_o (aw), .awburst_o (awburst), .awlen_o (awlen), .awid_o (awid),
    .awready_i (awready), .w_o (w), .wready_i (wready),
    .b_i (b), .bready_o (bready),
    .uart_data_o (uart_data), .uart_valid_o (uart_valid)
  );

  bus_checker u_chk (
    .clk (clk), .rst (rst),
    .ifu_rsp_i (ifu_rsp), .lsu_rsp_i (lsu_rsp),
    .ar_i (ar), .arburst_i (arburst), .arlen_i (arlen), .arid_i (arid),
    .rready_i (rready),
    .aw_i (aw), .awburst_i (awburst), .awlen_i (awlen), .awid_i (awid),
    .bready_i (bready), .w_i (w),
    .uart_data_i (uart_data), .uart_valid_i (uart_valid),
    .local_i (local_acc)
  );

  function automatic int next_delay();
    rnd_state = rnd_state ^ (rnd_state << 13);
    rnd_state = rnd_state ^ (rnd_state >> 17);
    rnd_state = rnd_state ^ (rnd_state << 5);
    return int'(rnd_state % 4);
  endfunction

  // handshakes seen at the rising edge
  always @(posedge clk)
  begin
    ar_hs <= ar.valid & arready;
    aw_hs <= aw.valid & awready;
    w_hs  <= w.valid & wready;
    if (ar.valid & arready)
      ar_addr <= ar.addr;
    if (aw.valid & awready)
      aw_addr <= aw.addr;
    if (w.valid & wready)
    begin
      w_data <= w.data;
      w_strb <= w.strb;
    end
  end

  // slave side driven on the falling edge
  always @(negedge clk)
  begin
    if (rst)
    begin
      arready = 1'b0;
      awready = 1'b0;
      wready = 1'b0;
      r = '0;
      b = '0;
      ar_cnt = -1;
      aw_cnt = -1;
      w_cnt = -1;
      aw_got = 1'b0;
      w_got = 1'b0;
    end
    else
    begin
      r.valid = 1'b0;
      b.valid = 1'b0;
      if (ar_hs)
      begin
        arready = 1'b0;
        ar_cnt = -1;
        r.valid = 1'b1;
        r.data = mem[ar_addr[10:3]];
        r.resp = (ar_addr == ERR_ADDR) ? 2'b10 : 2'b00;
      end
      else if (ar.valid)
      begin
        if (ar_cnt < 0)
          ar_cnt = next_delay();
        if (ar_cnt == 0)
          arready = 1'b1;
        else
          ar_cnt--;
      end
      if (aw_hs)
      begin
        awready = 1'b0;
        aw_cnt = -1;
        aw_got = 1'b1;
      end
      else if (aw.valid && !aw_got)
      begin
        if (aw_cnt < 0)
          aw_cnt = next_delay();
        if (aw_cnt == 0)
          awready = 1'b1;
        else
          aw_cnt--;
      end
      if (w_hs)
      begin
        wready = 1'b0;
        w_cnt = -1;
        w_got = 1'b1;
      end
      else if (w.valid && !w_got)
      begin
        if (w_cnt < 0)
          w_cnt = next_delay();
        if (w_cnt == 0)
          wready = 1'b1;
        else
          w_cnt--;
      end
      if (aw_got && w_got)
      begin
        for (int i = 0; i < 8; i++)
        begin
          if (w_strb[i])
            mem[aw_addr[10:3]][8*i +: 8] = w_data[8*i +: 8];
        end
        b.valid = 1'b1;
        b.resp = (aw_addr == ERR_ADDR) ? 2'b10 : 2'b00;
        aw_got = 1'b0;
        w_got = 1'b0;
      end
    end
  end

  task automatic add_row(input logic [95:0] name, input int port, input logic write,
                         input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] strb, input logic [31:0] exp);
    t_name[n_rows] = name;
    t_port[n_rows] = port;
    t_write[n_rows] = write;
    t_addr[n_rows] = addr;
    t_wdata[n_rows] = wdata;
    t_strb[n_rows] = strb;
    t_exp[n_rows] = exp;
    n_rows++;
  endtask

  // port 0 fetch, 1 load/store, 2 both at once
  task automatic apply_row(input int i);
    core_bus_pkg::core_req_t req;
    logic [31:0] a;
    logic [31:0] rdata;
    logic ifu_got, lsu_got, is_local, exp_err, chkd;
    logic [2:0] size;
    int cnt;
    a = t_addr[i];
    is_local = (a == `BUS_SERIAL_ADDR) || (a == `BUS_MTIME_ADDR) || (a == `BUS_MTIME_ADDR_UP);
    exp_err = (a == ERR_ADDR);
    chkd = !t_write[i] && (a != `BUS_MTIME_ADDR) && !exp_err;
    if (t_port[i] != 1)
      u_chk.push_rsp(0, t_name[i], t_exp[i], chkd, exp_err);
    if (t_port[i] != 0)
      u_chk.push_rsp(1, t_name[i], t_exp[i], chkd, exp_err);
    size = (t_strb[i] == 4'h1) ? 3'd0 : (t_strb[i] == 4'h3) ? 3'd1 : 3'd2;
    if (t_write[i] && !is_local)
    begin
      u_chk.push_aw(t_name[i], size, a[2] ? {t_strb[i], 4'h0} : {4'h0, t_strb[i]});
    end
    if (!t_write[i] && !is_local)
    begin
      // one AXI read per requester
      if (t_port[i] != 1)
        u_chk.push_ar(t_name[i], size);
      if (t_port[i] != 0)
        u_chk.push_ar(t_name[i], size);
    end
    if (t_write[i] && a == `BUS_SERIAL_ADDR)
      u_chk.push_uart(t_name[i], t_wdata[i][7:0]);
    req = '{valid: 1'b1, write: t_write[i], addr: a, wdata: t_wdata[i], strb: t_strb[i]};
    @(negedge clk);
    ifu_req = (t_port[i] != 1) ? req : '0;
    lsu_req = (t_port[i] != 0) ? req : '0;
    local_acc = is_local;
    ifu_got = (t_port[i] == 1);
    lsu_got = (t_port[i] == 0);
    cnt = 0;
    while (!(ifu_got && lsu_got))
    begin
      @(negedge clk);
      cnt++;
      if (lsu_rsp.valid)
      begin
        lsu_got = 1'b1;
        lsu_req = '0;
        rdata = lsu_rsp.rdata;
      end
      if (ifu_rsp.valid)
      begin
        if (!lsu_got)
          u_chk.report("fetch answered before the load/store request");
        ifu_got = 1'b1;
        ifu_req = '0;
        rdata = ifu_rsp.rdata;
      end
    end
    local_acc = 1'b0;
    if (is_local && cnt != 2)
      u_chk.report("local device did not respond 2 cycles after the request");
    if (a == `BUS_MTIME_ADDR)
    begin
      if (seen_lo && rdata <= last_lo)
        u_chk.report("timer low word did not increase");
      last_lo = rdata;
      seen_lo = 1'b1;
    end
  endtask

  initial
  begin
    ifu_req = '0;
    lsu_req = '0;
    local_acc = 1'b0;
    arready = 1'b0;
    awready = 1'b0;
    wready = 1'b0;
    r = '0;
    b = '0;
    // each word holds its own address pattern
    for (int i = 0; i < 256; i++)
      mem[i] = {32'hc0de_0000 ^ (i * 8 + 4), 32'hc0de_0000 ^ (i * 8)};
    add_row("ifu_even", 0, 1'b0, 32'h8000_0100, 32'h0, 4'hf, 32'hc0de_0100);
    add_row("ifu_odd", 0, 1'b0, 32'h8000_0104, 32'h0, 4'hf, 32'hc0de_0104);
    add_row("sb_even", 1, 1'b1, 32'h8000_0108, 32'h0000_00aa, 4'h1, 32'h0);
    add_row("lb_even", 1, 1'b0, 32'h8000_0108, 32'h0, 4'hf, 32'hc0de_01aa);
    add_row("sh_odd", 1, 1'b1, 32'h8000_010c, 32'h0000_bbcc, 4'h3, 32'h0);
    add_row("lh_odd", 1, 1'b0, 32'h8000_010c, 32'h0, 4'hf, 32'hc0de_bbcc);
    add_row("sw_odd", 1, 1'b1, 32'h8000_0114, 32'h1234_5678, 4'hf, 32'h0);
    add_row("lw_odd", 1, 1'b0, 32'h8000_0114, 32'h0, 4'hf, 32'h1234_5678);
    add_row("dual_rd", 2, 1'b0, 32'h8000_0110, 32'h0, 4'hf, 32'hc0de_0110);
    add_row("uart_wr", 1, 1'b1, `BUS_SERIAL_ADDR, 32'h0000_0041, 4'hf, 32'h0);
    add_row("mtime_lo", 1, 1'b0, `BUS_MTIME_ADDR, 32'h0, 4'hf, 32'h0);
    add_row("mtime_lo2", 0, 1'b0, `BUS_MTIME_ADDR, 32'h0, 4'hf, 32'h0);
    add_row("mtime_hi", 1, 1'b0, `BUS_MTIME_ADDR_UP, 32'h0, 4'hf, 32'h0);
    add_row("err_rd", 1, 1'b0, ERR_ADDR, 32'h0, 4'hf, 32'h0);
    add_row("after_err", 1, 1'b0, 32'h8000_0208, 32'h0, 4'hf, 32'hc0de_0208);
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_rows; i++)
      apply_row(i);
    repeat (3) @(negedge clk);
    u_chk.final_check();
    $display("checks %0d errors %0d assertion failures %0d", u_chk.checks, u_chk.errors,
             u_dut.u_props.failures);
    if (u_chk.errors == 0 && u_dut.u_props.failures == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired, a request was never answered");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: tests/bus_props.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module bus_props (
  input logic                    clk,
  input logic                    rst,
  input axi_bus_pkg::axi_ar_t    ar_o,
  input logic                    arready_i,
  input axi_bus_pkg::axi_aw_t    aw_o,
  input logic                    awready_i,
  input core_bus_pkg::core_rsp_t ifu_rsp_o,
  input core_bus_pkg::core_rsp_t lsu_rsp_o
);

  int failures = 0;

  // read address held until accepted
  a_ar_stable: assert property (@(posedge clk) disable iff (rst)
    (ar_o.valid && !arready_i) |=> (ar_o.valid && $stable(ar_o.addr)))
  else
  begin
    $error("read address channel changed before arready");
    failures++;
  end

  a_aw_stable: assert property (@(posedge clk) disable iff (rst)
    (aw_o.valid && !awready_i) |=> aw_o.valid)
  else
  begin
    $error("awvalid dropped before awready");
    failures++;
  end

  // one transaction at a time
  a_ar_aw_excl: assert property (@(posedge clk) disable iff (rst)
    !(ar_o.valid && aw_o.valid))
  else
  begin
    $error("arvalid and awvalid high together");
    failures++;
  end

  a_rsp_excl: assert property (@(posedge clk) disable iff (rst)
    !(ifu_rsp_o.valid && lsu_rsp_o.valid))
  else
  begin
    $error("both response ports valid together");
    failures++;
  end

endmodule

bind bus_top bus_props u_props (
  .clk       (clk),
  .rst       (rst),
  .ar_o      (ar_o),
  .arready_i (arready_i),
  .aw_o      (aw_o),
  .awready_i (awready_i),
  .ifu_rsp_o (ifu_rsp_o),
  .lsu_rsp_o (lsu_rsp_o)
);

// File: tests/bus_checker.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module bus_checker (
  input logic                    clk,
  input logic                    rst,
  input core_bus_pkg::core_rsp_t ifu_rsp_i,
  input core_bus_pkg::core_rsp_t lsu_rsp_i,
  input axi_bus_pkg::axi_ar_t    ar_i,
  input logic [1:0]              arburst_i,
  input logic [7:0]              arlen_i,
  input logic [3:0]              arid_i,
  input logic                    rready_i,
  input axi_bus_pkg::axi_aw_t    aw_i,
  input logic [1:0]              awburst_i,
  input logic [7:0]              awlen_i,
  input logic [3:0]              awid_i,
  input logic                    bready_i,
  input axi_bus_pkg::axi_w_t     w_i,
  input logic [7:0]              uart_data_i,
  input logic                    uart_valid_i,
  input logic                    local_i
);

  // one expected event, value is rdata, size or byte
  typedef struct packed {
    logic [95:0] name;
    logic [31:0] value;
    logic [7:0]  strb;
    logic        chk;
    logic        err;
  } exp_t;

  exp_t ifu_q[$];
  exp_t lsu_q[$];
  exp_t ar_q[$];
  exp_t aw_q[$];
  exp_t uart_q[$];
  exp_t e;
  int   errors = 0;
  int   checks = 0;
  logic ar_prev = 1'b0;
  logic aw_prev = 1'b0;

  task automatic compare(input logic [95:0] name, input logic [31:0] exp,
                         input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("FAIL %0s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic report(input string msg);
    errors++;
    $display("ERROR %0s", msg);
  endtask

  task automatic push_rsp(input int port, input logic [95:0] name, input logic [31:0] value,
                          input logic chk, input logic err);
    exp_t x;
    x = '{name: name, value: value, strb: 8'h0, chk: chk, err: err};
    if (port == 0)
    begin
      ifu_q.push_back(x);
    end
    else
    begin
      lsu_q.push_back(x);
    end
  endtask

  task automatic push_ar(input logic [95:0] name, input logic [2:0] size);
    ar_q.push_back('{name: name, value: {29'h0, size}, strb: 8'h0, chk: 1'b1, err: 1'b0});
  endtask

  task automatic push_aw(input logic [95:0] name, input logic [2:0] size,
                         input logic [7:0] strb);
    aw_q.push_back('{name: name, value: {29'h0, size}, strb: strb, chk: 1'b1, err: 1'b0});
  endtask

  task automatic push_uart(input logic [95:0] name, input logic [7:0] data);
    uart_q.push_back('{name: name, value: {24'h0, data}, strb: 8'h0, chk: 1'b1, err: 1'b0});
  endtask

  task automatic check_rsp(input exp_t x, input core_bus_pkg::core_rsp_t rsp);
    if (x.chk)
    begin
      compare(x.name, x.value, rsp.rdata);
    end
    compare(x.name, {31'h0, x.err}, {31'h0, rsp.err});
  endtask

  task automatic final_check();
    if (ifu_q.size() != 0 || lsu_q.size() != 0 || ar_q.size() != 0 || aw_q.size() != 0 ||
        uart_q.size() != 0)
    begin
      report("some expected responses or bus events never happened");
    end
  endtask

  // outputs come from registers, stable at the falling edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (ifu_rsp_i.valid)
      begin
        if (ifu_q.size() == 0)
          report("fetch port responded with nothing pending");
        else
          check_rsp(ifu_q.pop_front(), ifu_rsp_i);
      end
      if (lsu_rsp_i.valid)
      begin
        if (lsu_q.size() == 0)
          report("load/store port responded with nothing pending");
        else
          check_rsp(lsu_q.pop_front(), lsu_rsp_i);
      end
      // single beat reads, size from the strobe
      if (ar_i.valid && !ar_prev)
      begin
        if (ar_q.size() == 0)
        begin
          report("unexpected AXI read");
        end
        else
        begin
          e = ar_q.pop_front();
          compare(e.name, e.value, {29'h0, ar_i.size});
          compare(e.name, {30'h0, `BUS_AXI_INCR}, {30'h0, arburst_i});
          compare(e.name, 32'h0, {24'h0, arlen_i});
          compare(e.name, 32'h0, {28'h0, arid_i});
          compare(e.name, 32'h1, {31'h0, rready_i});
        end
      end
      ar_prev = ar_i.valid;
      // aw and w rise together
      if (aw_i.valid && !aw_prev)
      begin
        if (aw_q.size() == 0)
        begin
          report("unexpected AXI write");
        end
        else
        begin
          e = aw_q.pop_front();
          compare(e.name, e.value, {29'h0, aw_i.size});
          compare(e.name, {24'h0, e.strb}, {24'h0, w_i.strb});
          compare(e.name, {30'h0, `BUS_AXI_INCR}, {30'h0, awburst_i});
          compare(e.name, 32'h0, {24'h0, awlen_i});
          compare(e.name, 32'h0, {28'h0, awid_i});
          compare(e.name, 32'h1, {31'h0, w_i.last});
          compare(e.name, 32'h1, {31'h0, bready_i});
        end
      end
      aw_prev = aw_i.valid;
      if (uart_valid_i)
      begin
        if (uart_q.size() == 0)
        begin
          report("unexpected serial output");
        end
        else
        begin
          e = uart_q.pop_front();
          compare(e.name, e.value, {24'h0, uart_data_i});
        end
      end
      if (local_i && (ar_i.valid || aw_i.valid))
      begin
        report("AXI address valid during a local device access");
      end
    end
  end

endmodule

// File: hdl/bus_top.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module bus_top (
  input  logic                        clk,
  input  logic                        rst,
  input  core_bus_pkg::core_req_t     ifu_req_i,
  output core_bus_pkg::core_rsp_t     ifu_rsp_o,
  input  core_bus_pkg::core_req_t     lsu_req_i,
  output core_bus_pkg::core_rsp_t     lsu_rsp_o,
  output axi_bus_pkg::axi_ar_t        ar_o,
  output logic [1:0]                  arburst_o,
  output logic [`BUS_AXI_LEN_W-1:0]   arlen_o,
  output logic [`BUS_AXI_ID_W-1:0]    arid_o,
  input  logic                        arready_i,
  input  axi_bus_pkg::axi_r_t         r_i,
  output logic                        rready_o,
  output axi_bus_pkg::axi_aw_t        aw_o,
  output logic [1:0]                  awburst_o,
  output logic [`BUS_AXI_LEN_W-1:0]   awlen_o,
  output logic [`BUS_AXI_ID_W-1:0]    awid_o,
  input  logic                        awready_i,
  output axi_bus_pkg::axi_w_t         w_o,
  input  logic                        wready_i,
  input  axi_bus_pkg::axi_b_t         b_i,
  output logic                        bready_o,
  output logic [`BUS_UART_W-1:0]      uart_data_o,
  output logic                        uart_valid_o
);

  core_bus_pkg::decoded_t      lsu_dec;
  core_bus_pkg::decoded_t      ifu_dec;
  core_bus_pkg::bus_owner_e    owner;
  logic                        serial_we;
  logic [`BUS_UART_W-1:0]      serial_byte;
  logic                        mtime_hi;
  logic                        mtime_rd;
  logic [`BUS_DATA_W-1:0]      mtime_word;
  logic                        done;
  logic [`BUS_AXI_DATA_W-1:0]  data;
  logic                        err;

  // single beat, single id
  assign arburst_o = `BUS_AXI_INCR;
  assign arlen_o   = '0;
  assign arid_o    = '0;
  assign awburst_o = `BUS_AXI_INCR;
  assign awlen_o   = '0;
  assign awid_o    = '0;
  assign rready_o  = 1'b1;
  assign bready_o  = 1'b1;

  bus_addr_decode u_decode (
    .lsu_req_i (lsu_req_i),
    .ifu_req_i (ifu_req_i),
    .lsu_dec_o (lsu_dec),
    .ifu_dec_o (ifu_dec)
  );

  bus_txn_exec u_exec (
    .clk           (clk),
    .rst           (rst),
    .lsu_dec_i     (lsu_dec),
    .ifu_dec_i     (ifu_dec),
    .ar_o          (ar_o),
    .arready_i     (arready_i),
    .aw_o          (aw_o),
    .awready_i     (awready_i),
    .w_o           (w_o),
    .wready_i      (wready_i),
    .r_i           (r_i),
    .b_i           (b_i),
    .serial_we_o   (serial_we),
    .serial_byte_o (serial_byte),
    .mtime_hi_o    (mtime_hi),
    .mtime_rd_o    (mtime_rd),
    .done_o        (done),
    .owner_o       (owner),
    .data_o        (data),
    .err_o         (err)
  );

  // latched address drives ar addr, so bit 2 is the lane
  bus_resp_route u_result (
    .clk          (clk),
    .rst          (rst),
    .done_i       (done),
    .owner_i      (owner),
    .data_i       (data),
    .err_i        (err),
    .addr_lane_i  (ar_o.addr[2]),
    .mtime_word_i (mtime_word),
    .is_local_i   (mtime_rd),
    .ifu_rsp_o    (ifu_rsp_o),
    .lsu_rsp_o    (lsu_rsp_o)
  );

  clint_timer u_mtime (
    .clk    (clk),
    .rst    (rst),
    .rd_i   (mtime_rd),
    .hi_i   (mtime_hi),
    .word_o (mtime_word)
  );

  uart_tx_reg u_uart (
    .clk     (clk),
    .rst     (rst),
    .we_i    (serial_we),
    .byte_i  (serial_byte),
    .data_o  (uart_data_o),
    .valid_o (uart_valid_o)
  );

endmodule

// File: hdl/uart_tx_reg.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module uart_tx_reg (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   we_i,
  input  logic [`BUS_UART_W-1:0] byte_i,
  output logic [`BUS_UART_W-1:0] data_o,
  output logic                   valid_o
);

  logic [`BUS_UART_W-1:0] data_q;
  logic                   valid_q;

  // one pulse per write
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= we_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (we_i)
    begin
      data_q <= byte_i;
    end
  end

  assign data_o  = data_q;
  assign valid_o = valid_q;

endmodule

// File: hdl/clint_timer.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module clint_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rd_i,
  input  logic                   hi_i,
  output logic [`BUS_DATA_W-1:0] word_o
);

  logic [`BUS_MTIME_W-1:0] count_q;
  logic [`BUS_DATA_W-1:0]  hi_snap_q;

  // free running
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count_q <= '0;
    end
    else
    begin
      count_q <= count_q + 1'b1;
    end
  end

  // low read freezes the upper half for the next high read
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hi_snap_q <= '0;
    end
    else if (rd_i & ~hi_i)
    begin
      hi_snap_q <= count_q[`BUS_MTIME_W-1:`BUS_DATA_W];
    end
  end

  assign word_o = hi_i ? hi_snap_q : count_q[`BUS_DATA_W-1:0];

endmodule

// File: hdl/bus_resp_route.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module bus_resp_route (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         done_i,
  input  core_bus_pkg::bus_owner_e     owner_i,
  input  logic [`BUS_AXI_DATA_W-1:0]   data_i,
  input  logic                         err_i,
  input  logic                         addr_lane_i,
  input  logic [`BUS_DATA_W-1:0]       mtime_word_i,
  input  logic                         is_local_i,
  output core_bus_pkg::core_rsp_t      ifu_rsp_o,
  output core_bus_pkg::core_rsp_t      lsu_rsp_o
);

  logic                     valid_q;
  core_bus_pkg::bus_owner_e owner_q;
  logic [`BUS_DATA_W-1:0]   rdata_q;
  logic                     err_q;
  logic [`BUS_DATA_W-1:0]   word;
  logic                     to_ifu;

  // pick the 32 bit lane, or the timer word for local reads
  assign word = is_local_i  ? mtime_word_i :
                addr_lane_i ? data_i[`BUS_AXI_DATA_W-1:`BUS_DATA_W] :
                              data_i[`BUS_DATA_W-1:0];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= done_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (done_i)
    begin
      owner_q <= owner_i;
      rdata_q <= word;
      err_q   <= err_i;
    end
  end

  assign to_ifu = (owner_q == core_bus_pkg::OWNER_IFU);

  // idle port sees zeros
  assign ifu_rsp_o.valid = valid_q & to_ifu;
  assign ifu_rsp_o.rdata = to_ifu ? rdata_q : '0;
  assign ifu_rsp_o.err   = to_ifu & err_q;
  assign lsu_rsp_o.valid = valid_q & ~to_ifu;
  assign lsu_rsp_o.rdata = to_ifu ? '0 : rdata_q;
  assign lsu_rsp_o.err   = ~to_ifu & err_q;

endmodule

// File: hdl/bus_txn_exec.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module bus_txn_exec (
  input  logic                         clk,
  input  logic                         rst,
  input  core_bus_pkg::decoded_t       lsu_dec_i,
  input  core_bus_pkg::decoded_t       ifu_dec_i,
  output axi_bus_pkg::axi_ar_t         ar_o,
  input  logic                         arready_i,
  output axi_bus_pkg::axi_aw_t         aw_o,
  input  logic                         awready_i,
  output axi_bus_pkg::axi_w_t          w_o,
  input  logic                         wready_i,
  input  axi_bus_pkg::axi_r_t          r_i,
  input  axi_bus_pkg::axi_b_t          b_i,
  output logic                         serial_we_o,
  output logic [`BUS_UART_W-1:0]       serial_byte_o,
  output logic                         mtime_hi_o,
  output logic                         mtime_rd_o,
  output logic                         done_o,
  output core_bus_pkg::bus_owner_e     owner_o,
  output logic [`BUS_AXI_DATA_W-1:0]   data_o,
  output logic                         err_o
);

  typedef enum logic [2:0] {S_IDLE, S_AR, S_R, S_AW_W, S_B, S_LOCAL} state_e;

  state_e                   state_q;
  core_bus_pkg::decoded_t   req_q;
  core_bus_pkg::bus_owner_e owner_q;
  core_bus_pkg::decoded_t   sel;
  logic aw_pend_q;
  logic w_pend_q;
  logic done_q;
  logic lsu_ok;
  logic ifu_ok;
  logic go;
  logic aw_done;
  logic w_done;

  // the owner whose response is pulsing still holds its request
  assign lsu_ok = lsu_dec_i.req.valid & ~(done_q & (owner_q == core_bus_pkg::OWNER_LSU));
  assign ifu_ok = ifu_dec_i.req.valid & ~(done_q & (owner_q == core_bus_pkg::OWNER_IFU));
  assign go     = (state_q == S_IDLE) & (lsu_ok | ifu_ok);
  assign sel    = lsu_ok ? lsu_dec_i : ifu_dec_i;

  assign aw_done = ~aw_pend_q | awready_i;
  assign w_done  = ~w_pend_q | wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= S_IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      done_q    <= 1'b0;
    end
    else
    begin
      done_q <= done_o;
      case (state_q)
        S_IDLE:
        begin
          if (go)
          begin
            if (sel.target != core_bus_pkg::TGT_MEM)
            begin
              state_q <= S_LOCAL;
            end
            else if (sel.req.write)
            begin
              state_q   <= S_AW_W;
              aw_pend_q <= 1'b1;
              w_pend_q  <= 1'b1;
            end
            else
            begin
              state_q <= S_AR;
            end
          end
        end
        S_AR:
        begin
          if (arready_i)
          begin
            state_q <= S_R;
          end
        end
        S_R:
        begin
          if (r_i.valid)
          begin
            state_q <= S_IDLE;
          end
        end
        S_AW_W:
        begin
          // address and data channels finish independently
          if (awready_i)
          begin
            aw_pend_q <= 1'b0;
          end
          if (wready_i)
          begin
            w_pend_q <= 1'b0;
          end
          if (aw_done & w_done)
          begin
            state_q <= S_B;
          end
        end
        S_B:
        begin
          if (b_i.valid)
          begin
            state_q <= S_IDLE;
          end
        end
        default:
        begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (go)
    begin
      req_q   <= sel;
      owner_q <= lsu_ok ? core_bus_pkg::OWNER_LSU : core_bus_pkg::OWNER_IFU;
    end
  end

  // read channel
  assign ar_o.valid = (state_q == S_AR);
  assign ar_o.addr  = req_q.req.addr;
  assign ar_o.size  = req_q.size;

  // write channels, word steered by address bit 2
  assign aw_o.valid = (state_q == S_AW_W) & aw_pend_q;
  assign aw_o.addr  = req_q.req.addr;
  assign aw_o.size  = req_q.size;
  assign w_o.valid  = (state_q == S_AW_W) & w_pend_q;
  assign w_o.data   = req_q.req.addr[2] ? {req_q.req.wdata, 32'h0} : {32'h0, req_q.req.wdata};
  assign w_o.strb   = req_q.req.addr[2] ? {req_q.req.strb, 4'h0} : {4'h0, req_q.req.strb};
  assign w_o.last   = 1'b1;

  // serial byte is taken in the accept cycle
  assign serial_we_o   = go & sel.req.write & (sel.target == core_bus_pkg::TGT_SERIAL);
  assign serial_byte_o = sel.req.wdata[`BUS_UART_W-1:0];

  assign mtime_hi_o = (req_q.target == core_bus_pkg::TGT_MTIME_HI);
  assign mtime_rd_o = (state_q == S_LOCAL) & ~req_q.req.write &
                      ((req_q.target == core_bus_pkg::TGT_MTIME_LO) | mtime_hi_o);

  // completion
  assign done_o  = ((state_q == S_R) & r_i.valid) | ((state_q == S_B) & b_i.valid) |
                   (state_q == S_LOCAL);
  assign owner_o = owner_q;
  assign data_o  = (state_q == S_R) ? r_i.data : '0;
  assign err_o   = ((state_q == S_R) & (r_i.resp != 2'b00)) |
                   ((state_q == S_B) & (b_i.resp != 2'b00));

endmodule

// File: hdl/bus_addr_decode.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module bus_addr_decode (
  input  core_bus_pkg::core_req_t lsu_req_i,
  input  core_bus_pkg::core_req_t ifu_req_i,
  output core_bus_pkg::decoded_t  lsu_dec_o,
  output core_bus_pkg::decoded_t  ifu_dec_o
);

  function automatic core_bus_pkg::decoded_t decode(input core_bus_pkg::core_req_t req);
    core_bus_pkg::decoded_t d;
    d.req = req;
    // exact match on the device registers, all else is memory
    case (req.addr)
      `BUS_SERIAL_ADDR:   d.target = core_bus_pkg::TGT_SERIAL;
      `BUS_MTIME_ADDR:    d.target = core_bus_pkg::TGT_MTIME_LO;
      `BUS_MTIME_ADDR_UP: d.target = core_bus_pkg::TGT_MTIME_HI;
      default:            d.target = core_bus_pkg::TGT_MEM;
    endcase
    // byte, half, word from the strobe pattern
    case (req.strb)
      4'h1:    d.size = 3'd0;
      4'h3:    d.size = 3'd1;
      default: d.size = 3'd2;
    endcase
    return d;
  endfunction

  always_comb
  begin
    lsu_dec_o = decode(lsu_req_i);
    ifu_dec_o = decode(ifu_req_i);
  end

endmodule

// File: hdl/axi_bus_pkg.sv
`include "bus_settings.svh"

package axi_bus_pkg;

  // only the fields this master drives or uses
  typedef struct packed {
    logic                        valid;
    logic [`BUS_ADDR_W-1:0]      addr;
    logic [2:0]                  size;
  } axi_ar_t;

  typedef struct packed {
    logic                        valid;
    logic [`BUS_ADDR_W-1:0]      addr;
    logic [2:0]                  size;
  } axi_aw_t;

  typedef struct packed {
    logic                        valid;
    logic [`BUS_AXI_DATA_W-1:0]  data;
    logic [`BUS_AXI_DATA_W/8-1:0] strb;
    logic                        last;
  } axi_w_t;

  typedef struct packed {
    logic                        valid;
    logic [`BUS_AXI_DATA_W-1:0]  data;
    logic [1:0]                  resp;
  } axi_r_t;

  typedef struct packed {
    logic                        valid;
    logic [1:0]                  resp;
  } axi_b_t;

endpackage

// File: hdl/core_bus_pkg.sv
`include "bus_settings.svh"

package core_bus_pkg;

  // request as presented by fetch or load/store
  typedef struct packed {
    logic                      valid;
    logic                      write;
    logic [`BUS_ADDR_W-1:0]    addr;
    logic [`BUS_DATA_W-1:0]    wdata;
    logic [`BUS_DATA_W/8-1:0]  strb;
  } core_req_t;

  // single cycle result pulse
  typedef struct packed {
    logic                      valid;
    logic [`BUS_DATA_W-1:0]    rdata;
    logic                      err;
  } core_rsp_t;

  typedef enum logic [1:0] {
    TGT_MEM,
    TGT_SERIAL,
    TGT_MTIME_LO,
    TGT_MTIME_HI
  } bus_target_e;

  typedef enum logic {
    OWNER_IFU,
    OWNER_LSU
  } bus_owner_e;

  // request plus decode results
  typedef struct packed {
    core_req_t                 req;
    bus_target_e               target;
    logic [2:0]                size;
  } decoded_t;

endpackage

// File: hdl/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// core side word and address
`define BUS_DATA_W        32
`define BUS_ADDR_W        32

// axi master port
`define BUS_AXI_DATA_W    64
`define BUS_AXI_ID_W      4
`define BUS_AXI_LEN_W     8
`define BUS_AXI_INCR      2'b01

// local devices
`define BUS_UART_W        8
`define BUS_MTIME_W       64
`define BUS_SERIAL_ADDR   32'h1000_0000
`define BUS_MTIME_ADDR    32'ha000_0048
`define BUS_MTIME_ADDR_UP 32'ha000_004c

`endif
